// File: verilog.f
+incdir+common
common/spi_pkg.sv
common/bridge_pkg.sv
spi_slave/spi_slave_port.sv
bridge/bridge_sequencer.sv
sram_master/sram_spi_master.sv
src/spi_sram_bridge.sv
testbench/sram_spi_model.sv
testbench/tb_spi_sram_bridge.sv

// File: Makefile
TOP := tb_spi_sram_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_spi_sram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_sram_bridge;

    localparam int HALF_CLKS    = 20; // Host sck half period
    localparam int IDLE_TIMEOUT = 4000;
    localparam int FALL_TIMEOUT = 4;

    logic        clk;
    logic        rst;
    logic        spi_sck;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    logic        sram_sck;
    logic        sram_cs_n;
    logic        sram_mosi;
    logic        sram_miso;
    logic        idle;
    logic [7:0]  model_op;
    logic [23:0] model_addr;
    int          model_cmds;
    int          cs_low_clks = 0;
    logic [7:0]  wr_bytes [$];
    logic [7:0]  rd_bytes [$];

    spi_sram_bridge uut (
        .clk(clk), .rst(rst),
        .spi_sck(spi_sck), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .sram_sck(sram_sck), .sram_cs_n(sram_cs_n), .sram_mosi(sram_mosi),
        .sram_miso(sram_miso), .idle(idle)
    );

    sram_spi_model sram (
        .sram_sck(sram_sck), .sram_cs_n(sram_cs_n), .sram_mosi(sram_mosi),
        .sram_miso(sram_miso), .last_op(model_op), .last_addr(model_addr),
        .cmd_count(model_cmds)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!sram_cs_n) cs_low_clks <= cs_low_clks + 1; // Any SRAM activity
    end

    task automatic stop_on_timeout(input string what);
        $display("ERROR: timed out waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic spi_begin();
        int n;
        n = 0;
        spi_cs_n <= 1'b0;
        while (idle) begin
            if (n >= FALL_TIMEOUT) stop_on_timeout("idle to fall after cs");
            @(posedge clk);
            n++;
        end
        repeat (HALF_CLKS) @(posedge clk);
    endtask

    task automatic spi_end();
        int n;
        n = 0;
        repeat (HALF_CLKS) @(posedge clk);
        spi_cs_n <= 1'b1;
        @(posedge clk);
        while (!idle) begin
            if (n >= IDLE_TIMEOUT) stop_on_timeout("idle to rise after the frame");
            @(posedge clk);
            n++;
        end
        check_value(32'(sram_cs_n), 32'd1, "sram_cs_n high when idle");
        repeat (HALF_CLKS) @(posedge clk);
    endtask

    // Mode 0, MSB first, miso sampled at rising sck
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        logic [7:0] sh;
        sh = tx;
        rx = 8'h00;
        repeat (8) begin
            spi_mosi <= sh[7];
            sh = sh << 1;
            repeat (HALF_CLKS) @(posedge clk);
            rx = {rx[6:0], spi_miso};
            spi_sck <= 1'b1;
            repeat (HALF_CLKS) @(posedge clk);
            spi_sck <= 1'b0;
        end
    endtask

    task automatic send_header(input logic [7:0] op, input logic [23:0] addr);
        logic [7:0] junk;
        spi_xfer(op, junk);
        spi_xfer(addr[23:16], junk);
        spi_xfer(addr[15:8], junk);
        spi_xfer(addr[7:0], junk);
    endtask

    task automatic write_frame(input logic [23:0] addr);
        logic [7:0] junk;
        spi_begin();
        send_header(8'h02, addr);
        foreach (wr_bytes[i]) spi_xfer(wr_bytes[i], junk);
        spi_end();
    endtask

    task automatic read_frame(input logic [23:0] addr, input int count);
        logic [7:0] data;
        rd_bytes.delete();
        spi_begin();
        send_header(8'h03, addr);
        spi_xfer(8'h00, data); // Dummy byte covers the first SRAM access
        repeat (count) begin
            spi_xfer(8'h00, data);
            rd_bytes.push_back(data);
        end
        spi_end();
    endtask

    initial begin
        logic [23:0] addr_a;
        logic [23:0] addr_b;
        logic [7:0]  byte_a;
        logic [23:0] addrs [3];
        logic [7:0]  datas [3];
        logic [7:0]  junk;
        int          cs_before;
        int          cmds_before;

        spi_sck  <= 1'b0;
        spi_cs_n <= 1'b1;
        spi_mosi <= 1'b0;
        rst      <= 1'b1;
        void'($urandom(32'h1b7f7b5c));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // Reset state
        check_value(32'(sram_cs_n), 32'd1, "sram_cs_n after reset");
        check_value(32'(spi_miso), 32'd0, "spi_miso after reset");
        check_value(32'(idle), 32'd1, "idle after reset");

        // Single byte write then read
        addr_a = 24'($urandom());
        byte_a = 8'($urandom());
        wr_bytes = '{byte_a};
        write_frame(addr_a);
        check_value(32'(model_op), 32'h02, "model opcode after write");
        check_value(32'(model_addr), 32'(addr_a), "model address after write");
        read_frame(addr_a, 1);
        check_value(32'(rd_bytes[0]), 32'(byte_a), "single byte read data");
        check_value(32'(model_op), 32'h03, "model opcode after read");
        check_value(32'(model_addr), 32'(addr_a), "model address after read");

        // Four byte bursts
        addr_b = 24'($urandom());
        wr_bytes.delete();
        repeat (4) wr_bytes.push_back(8'($urandom()));
        write_frame(addr_b);
        foreach (wr_bytes[i]) begin
            check_value(32'(sram.read_byte(addr_b + 24'(i))), 32'(wr_bytes[i]),
                        "model burst contents");
        end
        read_frame(addr_b, 4);
        foreach (wr_bytes[i]) begin
            check_value(32'(rd_bytes[i]), 32'(wr_bytes[i]), "burst read data");
        end

        // Unsupported opcode leaves the SRAM alone
        cs_before   = cs_low_clks;
        cmds_before = model_cmds;
        spi_begin();
        send_header(8'h0b, addr_a);
        spi_xfer(8'ha5, junk);
        spi_xfer(8'h5a, junk);
        spi_end();
        check_value(32'(cs_low_clks), 32'(cs_before), "sram_cs_n low during opcode 0x0b");
        check_value(32'(model_cmds), 32'(cmds_before), "model commands after opcode 0x0b");
        read_frame(addr_a, 1);
        check_value(32'(rd_bytes[0]), 32'(byte_a), "read after opcode 0x0b");

        // Back to back frames, one fresh command each
        for (int k = 0; k < 3; k++) begin
            addrs[k]    = 24'($urandom());
            datas[k]    = 8'($urandom());
            wr_bytes    = '{datas[k]};
            cmds_before = model_cmds;
            write_frame(addrs[k]);
            check_value(32'(model_cmds), 32'(cmds_before + 1), "one command per write frame");
            check_value(32'(model_addr), 32'(addrs[k]), "write frame address");
        end
        for (int k = 0; k < 3; k++) begin
            cmds_before = model_cmds;
            read_frame(addrs[k], 1);
            check_value(32'(model_cmds), 32'(cmds_before + 1), "one command per read frame");
            check_value(32'(model_op), 32'h03, "read frame opcode");
            check_value(32'(rd_bytes[0]), 32'(datas[k]), "back to back read data");
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/sram_spi_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spi_model (
    input  logic        sram_sck,
    input  logic        sram_cs_n,
    input  logic        sram_mosi,
    output logic        sram_miso,
    output logic [7:0]  last_op,
    output logic [23:0] last_addr,
    output int          cmd_count
);

    logic [7:0]  mem [logic [23:0]]; // Sparse, only written cells exist
    logic [31:0] cmd_shift;
    logic [7:0]  data_shift;
    logic [7:0]  rd_byte;
    int          bit_cnt = 0;

    // Unwritten cells read back a pattern of the full address
    function automatic logic [7:0] read_byte(input logic [23:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'h5a;
    endfunction

    initial begin
        sram_miso = 1'b0;
        last_op   = 8'h00;
        last_addr = 24'h000000;
        cmd_count = 0;
    end

    always @(posedge sram_sck or posedge sram_cs_n) begin
        if (sram_cs_n) begin
            bit_cnt = 0;
        end else begin
            if (bit_cnt < 32) begin
                cmd_shift = {cmd_shift[30:0], sram_mosi};
                if (bit_cnt == 31) begin // Opcode and address complete
                    last_op   = cmd_shift[31:24];
                    last_addr = cmd_shift[23:0];
                    cmd_count++;
                end
            end else begin
                data_shift = {data_shift[6:0], sram_mosi};
                if (last_op == 8'h02 && bit_cnt % 8 == 7) begin
                    mem[last_addr + 24'((bit_cnt - 32) / 8)] = data_shift;
                end
            end
            bit_cnt++;
        end
    end

    // Mode 0 output, next bit on falling sck
    always @(negedge sram_sck or posedge sram_cs_n) begin
        if (sram_cs_n) begin
            sram_miso = 1'b0;
        end else if (last_op == 8'h03 && bit_cnt >= 32) begin
            rd_byte   = read_byte(last_addr + 24'((bit_cnt - 32) / 8));
            rd_byte   = rd_byte << ((bit_cnt - 32) % 8);
            sram_miso = rd_byte[7];
        end
    end

endmodule

`default_nettype wire

// File: src/spi_sram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module spi_sram_bridge
    import spi_pkg::*, bridge_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic spi_sck,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic sram_sck,
    output logic sram_cs_n,
    output logic sram_mosi,
    input  logic sram_miso,
    output logic idle
);

    spi_byte_t  rx_byte;
    logic       rx_valid;
    logic       frame_active;
    logic       tx_taken;
    spi_byte_t  tx_byte;
    logic       tx_load;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    sram_addr_t wb_adr;
    spi_byte_t  wb_dat_w;
    spi_byte_t  wb_dat_r;
    logic       wb_ack;

    spi_slave_port u_slave (
        .clk, .rst, .spi_sck, .spi_cs_n, .spi_mosi, .spi_miso,
        .rx_byte, .rx_valid, .frame_active, .tx_taken, .tx_byte, .tx_load
    );

    bridge_sequencer u_seq (
        .clk, .rst, .rx_byte, .rx_valid, .frame_active, .tx_taken, .tx_byte, .tx_load,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .idle
    );

    sram_spi_master #(.CLK_DIV(`SRAM_CLK_DIV)) u_sram (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .sram_sck, .sram_cs_n, .sram_mosi, .sram_miso
    );

endmodule

`default_nettype wire

// File: sram_master/sram_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module sram_spi_master
    import spi_pkg::*, bridge_pkg::*;
#(
    parameter int CLK_DIV = `SRAM_CLK_DIV
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  sram_addr_t wb_adr,
    input  spi_byte_t  wb_dat_w,
    output spi_byte_t  wb_dat_r,
    output logic       wb_ack,
    output logic       sram_sck,
    output logic       sram_cs_n,
    output logic       sram_mosi,
    input  logic       sram_miso
);

    localparam int CMD_BITS = `SPI_BYTE_BITS + `SRAM_ADDR_BITS;
    localparam int CNT_W    = $clog2(CMD_BITS);
    localparam int DIV_W    = $clog2(CLK_DIV + 1);

    sram_state_e         state;
    logic [DIV_W-1:0]    div_cnt;
    logic [CNT_W-1:0]    bit_cnt;
    logic [CMD_BITS-1:0] tx_shift;
    spi_byte_t           rx_shift;
    spi_opcode_e         opcode;
    logic                shifting;
    logic                tick;
    logic                sck_rise;
    logic                sck_fall;
    logic                last_bit;

    assign opcode    = wb_we ? OP_WRITE : OP_READ;
    assign shifting  = (state == SRAM_SEND_CMD) || (state == SRAM_XFER_BYTE);
    assign tick      = shifting && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign sck_rise  = tick && !sram_sck;
    assign sck_fall  = tick && sram_sck;
    assign last_bit  = (bit_cnt == '0);
    assign sram_mosi = tx_shift[CMD_BITS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SRAM_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            tx_shift  <= '0;
            sram_sck  <= 1'b0;
            sram_cs_n <= 1'b1;
            wb_ack    <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (shifting) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
            end
            if (sck_rise) begin
                sram_sck <= 1'b1;
            end
            if (sck_fall) begin // Next bit goes out while sck is low
                sram_sck <= 1'b0;
                tx_shift <= tx_shift << 1;
                bit_cnt  <= bit_cnt - 1'b1;
            end
            case (state)
                SRAM_IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        sram_cs_n <= 1'b0;
                        tx_shift  <= {opcode, wb_adr};
                        bit_cnt   <= CNT_W'(CMD_BITS - 1);
                        div_cnt   <= '0;
                        state     <= SRAM_SEND_CMD;
                    end
                end
                SRAM_SEND_CMD: begin
                    if (sck_fall && last_bit) begin
                        tx_shift <= {wb_dat_w, {`SRAM_ADDR_BITS{1'b0}}};
                        bit_cnt  <= CNT_W'(`SPI_BYTE_BITS - 1);
                        state    <= SRAM_XFER_BYTE;
                    end
                end
                SRAM_XFER_BYTE: begin
                    if (sck_fall && last_bit) begin
                        wb_ack <= 1'b1;
                        state  <= SRAM_ACK;
                    end
                end
                SRAM_ACK: state <= SRAM_HOLD;
                SRAM_HOLD: begin
                    // cs stays low, SRAM keeps its address counter
                    if (!wb_cyc) begin
                        sram_cs_n <= 1'b1;
                        state     <= SRAM_IDLE;
                    end else if (wb_stb) begin
                        tx_shift <= {wb_dat_w, {`SRAM_ADDR_BITS{1'b0}}};
                        bit_cnt  <= CNT_W'(`SPI_BYTE_BITS - 1);
                        div_cnt  <= '0;
                        state    <= SRAM_XFER_BYTE;
                    end
                end
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[`SPI_BYTE_BITS-2:0], sram_miso};
        end
        if (state == SRAM_XFER_BYTE && sck_fall && last_bit) begin
            wb_dat_r <= rx_shift;
        end
    end

    a_ack_with_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb);

endmodule

`default_nettype wire

// File: bridge/bridge_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module bridge_sequencer
    import spi_pkg::*, bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  spi_byte_t  rx_byte,
    input  logic       rx_valid,
    input  logic       frame_active,
    input  logic       tx_taken,
    output spi_byte_t  tx_byte,
    output logic       tx_load,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output sram_addr_t wb_adr,
    output spi_byte_t  wb_dat_w,
    input  spi_byte_t  wb_dat_r,
    input  logic       wb_ack,
    output logic       idle
);

    localparam int ADDR_BYTES = `SRAM_ADDR_BITS / `SPI_BYTE_BITS;
    localparam int ADDR_KEEP  = `SRAM_ADDR_BITS - `SPI_BYTE_BITS;

    seq_state_e state;
    logic [1:0] addr_cnt;
    logic       addr_last;
    logic       wr_accept;

    assign addr_last = (addr_cnt == 2'(ADDR_BYTES - 1));
    assign wr_accept = (state == SEQ_WRITE_DATA) && frame_active && rx_valid && !wb_stb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            addr_cnt <= '0;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            tx_load  <= 1'b0;
            idle     <= 1'b1;
        end else begin
            tx_load <= 1'b0;
            idle    <= (state == SEQ_IDLE) && !frame_active;
            case (state)
                SEQ_IDLE: begin
                    if (frame_active) begin
                        state <= SEQ_OPCODE;
                    end
                end
                SEQ_OPCODE: begin
                    if (!frame_active) begin
                        state <= SEQ_IDLE;
                    end else if (rx_valid) begin
                        addr_cnt <= '0;
                        case (rx_byte)
                            OP_WRITE: begin
                                wb_we <= 1'b1;
                                state <= SEQ_ADDR;
                            end
                            OP_READ: begin
                                wb_we <= 1'b0;
                                state <= SEQ_ADDR;
                            end
                            default: state <= SEQ_DRAIN; // Unsupported, sit out the frame
                        endcase
                    end
                end
                SEQ_ADDR: begin
                    if (!frame_active) begin
                        state <= SEQ_IDLE;
                    end else if (rx_valid) begin
                        addr_cnt <= addr_cnt + 2'd1;
                        if (addr_last) begin
                            wb_cyc <= 1'b1;
                            if (wb_we) begin
                                state <= SEQ_WRITE_DATA;
                            end else begin
                                wb_stb <= 1'b1; // First fetch right away
                                state  <= SEQ_READ_FETCH;
                            end
                        end
                    end
                end
                SEQ_WRITE_DATA: begin
                    if (wb_stb) begin
                        if (wb_ack) begin
                            wb_stb <= 1'b0;
                        end
                    end else if (!frame_active) begin
                        wb_cyc <= 1'b0;
                        state  <= SEQ_IDLE;
                    end else if (wr_accept) begin
                        wb_stb <= 1'b1;
                    end
                end
                SEQ_READ_FETCH: begin
                    // tx_taken of the dummy byte start lands here and is dropped
                    if (wb_ack) begin
                        wb_stb  <= 1'b0;
                        tx_load <= 1'b1;
                        state   <= SEQ_READ_STREAM;
                    end
                end
                SEQ_READ_STREAM: begin
                    if (!frame_active) begin
                        wb_cyc <= 1'b0;
                        state  <= SEQ_IDLE;
                    end else if (tx_taken) begin
                        wb_stb <= 1'b1;
                        state  <= SEQ_READ_FETCH;
                    end
                end
                SEQ_DRAIN: begin
                    if (!frame_active) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_ADDR && rx_valid) begin
            wb_adr <= {wb_adr[ADDR_KEEP-1:0], rx_byte}; // MSB first
        end
        if (wr_accept) begin
            wb_dat_w <= rx_byte;
        end
        if (state == SEQ_READ_FETCH && wb_ack) begin
            tx_byte <= wb_dat_r;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

endmodule

`default_nettype wire

// File: spi_slave/spi_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module spi_slave_port
    import spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      spi_sck,
    input  logic      spi_cs_n,
    input  logic      spi_mosi,
    output logic      spi_miso,
    output spi_byte_t rx_byte,
    output logic      rx_valid,
    output logic      frame_active,
    output logic      tx_taken,
    input  spi_byte_t tx_byte,
    input  logic      tx_load
);

    localparam int BIT_W = $clog2(`SPI_BYTE_BITS);

    logic [1:0]       sck_sync;
    logic [1:0]       cs_sync;
    logic [1:0]       mosi_sync;
    logic             sck_prev;
    logic             sck_rise;
    logic             sck_fall;
    logic [BIT_W-1:0] bit_cnt;
    logic             byte_done;
    spi_byte_t        shift_in;
    spi_byte_t        shift_out;
    spi_byte_t        tx_buf;

    // Two flop synchronizers, bit 1 is the safe copy
    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sync  <= 2'b00;
            cs_sync   <= 2'b11;
            mosi_sync <= 2'b00;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sck_prev  <= sck_sync[1];
        end
    end

    assign sck_rise     = sck_sync[1] & ~sck_prev;
    assign sck_fall     = ~sck_sync[1] & sck_prev;
    assign frame_active = ~cs_sync[1];
    assign byte_done    = frame_active && sck_rise && (bit_cnt == BIT_W'(`SPI_BYTE_BITS - 1));
    assign spi_miso     = shift_out[`SPI_BYTE_BITS-1]; // MSB first

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            tx_taken  <= 1'b0;
            shift_out <= '0;
            tx_buf    <= '0;
        end else begin
            rx_valid <= byte_done;
            tx_taken <= 1'b0;
            if (tx_load) begin
                tx_buf <= tx_byte;
            end
            if (!frame_active) begin
                bit_cnt   <= '0;
                shift_out <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (sck_fall) begin
                if (bit_cnt == '0) begin // Byte boundary
                    shift_out <= tx_buf;
                    tx_taken  <= 1'b1;
                end else begin
                    shift_out <= {shift_out[`SPI_BYTE_BITS-2:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_active && sck_rise) begin
            shift_in <= {shift_in[`SPI_BYTE_BITS-2:0], mosi_sync[1]};
        end
        if (byte_done) begin
            rx_byte <= {shift_in[`SPI_BYTE_BITS-2:0], mosi_sync[1]};
        end
    end

endmodule

`default_nettype wire

// File: common/bridge_pkg.sv
`default_nettype none

`include "bridge_settings.svh"

package bridge_pkg;

    typedef logic [`SRAM_ADDR_BITS-1:0] sram_addr_t;

    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_OPCODE, SEQ_ADDR, SEQ_WRITE_DATA, SEQ_READ_FETCH, SEQ_READ_STREAM, SEQ_DRAIN
    } seq_state_e;

    typedef enum logic [2:0] {
        SRAM_IDLE, SRAM_SEND_CMD, SRAM_XFER_BYTE, SRAM_ACK, SRAM_HOLD
    } sram_state_e;

endpackage

`default_nettype wire

// File: common/spi_pkg.sv
`default_nettype none

`include "bridge_settings.svh"

package spi_pkg;

    typedef logic [`SPI_BYTE_BITS-1:0] spi_byte_t;

    // Host and SRAM share the same command set
    typedef enum logic [7:0] {
        OP_WRITE = 8'h02,
        OP_READ  = 8'h03
    } spi_opcode_e;

endpackage

`default_nettype wire

// File: common/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// SRAM byte address
`define SRAM_ADDR_BITS 24

`define SPI_BYTE_BITS 8

// clk cycles per SRAM sck half period
`define SRAM_CLK_DIV 2

`endif
